/* tama_settings.svh */
// tama core settings
// bridge register map, ROM window, divider reloads and reset lengths

`ifndef TAMA_SETTINGS_SVH
`define TAMA_SETTINGS_SVH

////////////////////////////////////////
// bridge register map

// any write here starts the soft reset
`define TAMA_ADDR_RESET 32'h0000_0000
// bit 0 mutes the buzzer
`define TAMA_ADDR_SOUND 32'h0000_0010
// bits 1:0 turbo code, readable
`define TAMA_ADDR_TURBO 32'h0000_0100
// bit 0 drops turbo when the buzzer sounds
`define TAMA_ADDR_CANCEL 32'h0000_0104

// bridge address bits 31:28 for the program ROM window
`define TAMA_ROM_WINDOW 4'h1

////////////////////////////////////////
// divider reload values, one CPU tick every reload + 1 system clocks

`define TAMA_DIV_1X 12'd3600
`define TAMA_DIV_4X 12'd900
`define TAMA_DIV_50X 12'd72

// soft reset hold, short enough for simulation
`define TAMA_RESET_HOLD_W 11
`define TAMA_RESET_HOLD 11'd1024

// savestate reset length in 2x ticks
`define TAMA_SS_RESET_TICKS 3'd4

`endif

/* tama_pkg.sv */
// tama core types
// shared widths for the bridge, divider, program ROM and CPU side

package tama_pkg;

  // host bridge
  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;

  // turbo speed code as written by the host
  typedef logic [1:0] turbo_t;

  typedef enum turbo_t {
    turbo_1x   = 2'd0,
    turbo_4x   = 2'd1,
    turbo_50x  = 2'd2,
    turbo_full = 2'd3
  } turbo_e;

  // divider count and reload
  typedef logic [11:0] div_count_t;

  // program ROM, 16-bit storage with 12-bit instructions
  typedef logic [12:0] rom_addr_t;
  typedef logic [15:0] rom_word_t;
  typedef logic [11:0] rom_data_t;

  // CPU side
  typedef logic [14:0] audio_sample_t;
  typedef logic [2:0] ss_tick_t;

endpackage

/* bridge_if.sv */
// host bridge bus
// write strobe plus combinational read, no wait states

interface bridge_if import tama_pkg::*; ();

  bridge_addr_t addr;
  logic         wr;
  bridge_data_t wr_data;
  logic         rd;
  bridge_data_t rd_data;

  // host side, the top level drives the request
  modport host (output addr, output wr, output wr_data, output rd, input rd_data);

  // settings registers decode writes and answer reads
  modport regs (input addr, input wr, input wr_data, input rd, output rd_data);

  // program ROM only listens to writes in its window
  modport rom (input addr, input wr, input wr_data);

endinterface

/* bridge_regs.sv */
// settings registers on the host bridge
// soft reset countdown, sound mute, turbo speed and cancel-on-buzzer,
// with turbo readable back over the bridge

`include "tama_settings.svh"

module bridge_regs import tama_pkg::*; (
  input  logic           clk_sys_117_964,
  input  logic           reset_turbo_s,
  bridge_if.regs         bus,
  input  logic           buzzer,
  output turbo_t         turbo,
  output logic           soft_reset,
  output logic           sound_mute
);

  logic                          cancel_on_buzzer;
  logic [`TAMA_RESET_HOLD_W-1:0] hold_count;

  ////////////////////////////////////////
  // register writes

  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      turbo            <= turbo_1x;
      sound_mute       <= 1'b0;
      cancel_on_buzzer <= 1'b0;
    end else begin
      if (bus.wr) begin
        case (bus.addr)
          `TAMA_ADDR_SOUND: begin
            sound_mute <= bus.wr_data[0];
          end
          `TAMA_ADDR_TURBO: begin
            turbo <= bus.wr_data[1:0];
          end
          `TAMA_ADDR_CANCEL: begin
            cancel_on_buzzer <= bus.wr_data[0];
          end
          default: begin
          end
        endcase
      end

      // buzzer event drops back to normal speed, wins over a turbo write
      if (cancel_on_buzzer && buzzer) begin
        turbo <= turbo_1x;
      end
    end
  end

  ////////////////////////////////////////
  // soft reset countdown

  // loaded on the write edge, so the hold starts on the next cycle
  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      hold_count <= '0;
    end else if (bus.wr && bus.addr == `TAMA_ADDR_RESET) begin
      hold_count <= `TAMA_RESET_HOLD;
    end else if (hold_count != '0) begin
      hold_count <= hold_count - 1'b1;
    end
  end

  assign soft_reset = (hold_count != '0);

  ////////////////////////////////////////
  // read mux

  // only turbo is readable, data is presented while rd is high
  always_comb begin
    bus.rd_data = '0;
    if (bus.rd && bus.addr == `TAMA_ADDR_TURBO) begin
      bus.rd_data = bridge_data_t'(turbo);
    end
  end

endmodule

/* clock_enable_gen.sv */
// CPU clock enable divider
// 1x and 2x enables from the system clock, rate picked by the turbo code

`include "tama_settings.svh"

module clock_enable_gen import tama_pkg::*; (
  input  logic   clk_sys_117_964,
  input  logic   reset_turbo_s,
  input  turbo_t turbo,
  output logic   clk_en,
  output logic   clk_2x_en
);

  div_count_t reload;
  div_count_t count;

  // reload per speed, zero means run every cycle
  always_comb begin
    case (turbo_e'(turbo))
      turbo_1x:   reload = `TAMA_DIV_1X;
      turbo_4x:   reload = `TAMA_DIV_4X;
      turbo_50x:  reload = `TAMA_DIV_50X;
      turbo_full: reload = '0;
      default:    reload = `TAMA_DIV_1X;
    endcase
  end

  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      count     <= `TAMA_DIV_1X;
      clk_en    <= 1'b0;
      clk_2x_en <= 1'b0;
    end else if (reload == '0) begin
      // full speed, 2x every cycle and 1x every other
      clk_en    <= ~clk_en;
      clk_2x_en <= 1'b1;
    end else begin
      clk_en    <= 1'b0;
      clk_2x_en <= 1'b0;
      if (count == '0) begin
        count     <= reload;
        clk_en    <= 1'b1;
        clk_2x_en <= 1'b1;
      end else begin
        count <= count - 1'b1;
        // second 2x tick halfway through the period
        if (count == (reload >> 1)) begin
          clk_2x_en <= 1'b1;
        end
      end
    end
  end

endmodule

/* program_rom.sv */
// program ROM for the CPU
// loaded 32 bits at a time through the bridge window, two 16-bit words
// per write, and read synchronously by the CPU

`include "tama_settings.svh"

module program_rom import tama_pkg::*; (
  input  logic      clk_sys_117_964,
  bridge_if.rom     bus,
  input  rom_addr_t rom_addr,
  output rom_data_t rom_data
);

  // even words come from the upper half of a bridge word, odd from the lower
  rom_word_t even_bank [4096];
  rom_word_t odd_bank  [4096];

  logic [11:0] wr_index;
  logic [11:0] rd_index;
  logic        rom_write;

  rom_data_t   even_q;
  rom_data_t   odd_q;
  logic        odd_sel_q;

  assign wr_index  = bus.addr[13:2];
  assign rd_index  = rom_addr[12:1];
  assign rom_write = bus.wr && (bus.addr[31:28] == `TAMA_ROM_WINDOW);

  ////////////////////////////////////////
  // load path

  // bridge is big endian, each half is stored byte swapped
  always_ff @(posedge clk_sys_117_964) begin
    if (rom_write) begin
      even_bank[wr_index] <= {bus.wr_data[23:16], bus.wr_data[31:24]};
      odd_bank[wr_index]  <= {bus.wr_data[7:0], bus.wr_data[15:8]};
    end
  end

  ////////////////////////////////////////
  // CPU read path

  // both banks read every cycle, bank select follows one cycle later
  always_ff @(posedge clk_sys_117_964) begin
    even_q    <= even_bank[rd_index][11:0];
    odd_q     <= odd_bank[rd_index][11:0];
    odd_sel_q <= rom_addr[0];
  end

  assign rom_data = odd_sel_q ? odd_q : even_q;

endmodule

/* cpu_control.sv */
// CPU control
// savestate halt on the enables, merged CPU reset with the savestate
// reset tick counter, and the buzzer audio sample

`include "tama_settings.svh"

module cpu_control import tama_pkg::*; (
  input  logic          clk_sys_117_964,
  input  logic          reset_turbo_s,
  input  logic          clk_en,
  input  logic          clk_2x_en,
  input  logic          ss_halt,
  input  logic          ss_begin_reset,
  input  logic          soft_reset,
  input  logic          sound_mute,
  input  logic          buzzer,
  output logic          cpu_clk_en,
  output logic          cpu_clk_2x_en,
  output logic          cpu_reset,
  output audio_sample_t audio_sample
);

  ss_tick_t ss_ticks;

  // savestate halt freezes the CPU
  assign cpu_clk_en    = clk_en && !ss_halt;
  assign cpu_clk_2x_en = clk_2x_en && !ss_halt;

  // hold the CPU in reset for a few 2x ticks after a savestate load begins
  // counts on the ungated enable so a halt does not stall it
  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      ss_ticks <= '0;
    end else if (ss_begin_reset) begin
      ss_ticks <= `TAMA_SS_RESET_TICKS;
    end else if (ss_ticks != '0 && clk_2x_en) begin
      ss_ticks <= ss_ticks - 1'b1;
    end
  end

  assign cpu_reset = reset_turbo_s || soft_reset || (ss_ticks != '0);

  // buzzer is a square wave at a fixed level
  assign audio_sample = (buzzer && !sound_mute) ? audio_sample_t'(15'h1fff) : '0;

endmodule

/* tama_core_top.sv */
// tama core top level
// host bridge settings, CPU clock enables, program ROM and CPU control,
// all on the system clock

module tama_core_top import tama_pkg::*; (
  input  logic          clk_sys_117_964,
  input  logic          reset_turbo_s,

  // host bridge
  input  bridge_addr_t  bridge_addr,
  input  logic          bridge_wr,
  input  logic          bridge_rd,
  input  bridge_data_t  bridge_wr_data,
  output bridge_data_t  bridge_rd_data,

  // CPU side
  input  rom_addr_t     rom_addr,
  output rom_data_t     rom_data,
  input  logic          buzzer,
  input  logic          ss_halt,
  input  logic          ss_begin_reset,
  output logic          cpu_clk_en,
  output logic          cpu_clk_2x_en,
  output logic          cpu_reset,
  output audio_sample_t audio_sample
);

  turbo_t turbo;
  logic   soft_reset;
  logic   sound_mute;
  logic   clk_en;
  logic   clk_2x_en;

  ////////////////////////////////////////
  // bridge, host side of the interface

  bridge_if bus ();

  assign bus.addr       = bridge_addr;
  assign bus.wr         = bridge_wr;
  assign bus.wr_data    = bridge_wr_data;
  assign bus.rd         = bridge_rd;
  assign bridge_rd_data = bus.rd_data;

  ////////////////////////////////////////
  // blocks

  bridge_regs bridge_regs_inst (
    .clk_sys_117_964 (clk_sys_117_964),
    .reset_turbo_s   (reset_turbo_s),
    .bus             (bus),
    .buzzer          (buzzer),
    .turbo           (turbo),
    .soft_reset      (soft_reset),
    .sound_mute      (sound_mute)
  );

  clock_enable_gen clock_enable_gen_inst (
    .clk_sys_117_964 (clk_sys_117_964),
    .reset_turbo_s   (reset_turbo_s),
    .turbo           (turbo),
    .clk_en          (clk_en),
    .clk_2x_en       (clk_2x_en)
  );

  program_rom program_rom_inst (
    .clk_sys_117_964 (clk_sys_117_964),
    .bus             (bus),
    .rom_addr        (rom_addr),
    .rom_data        (rom_data)
  );

  cpu_control cpu_control_inst (
    .clk_sys_117_964 (clk_sys_117_964),
    .reset_turbo_s   (reset_turbo_s),
    .clk_en          (clk_en),
    .clk_2x_en       (clk_2x_en),
    .ss_halt         (ss_halt),
    .ss_begin_reset  (ss_begin_reset),
    .soft_reset      (soft_reset),
    .sound_mute      (sound_mute),
    .buzzer          (buzzer),
    .cpu_clk_en      (cpu_clk_en),
    .cpu_clk_2x_en   (cpu_clk_2x_en),
    .cpu_reset       (cpu_reset),
    .audio_sample    (audio_sample)
  );

endmodule

/* tama_asserts.sv */
// concurrent checks on the tama core top level
// enable pairing, savestate halt and the merged CPU reset

module tama_asserts (
  input logic clk_sys_117_964,
  input logic reset_turbo_s,
  input logic ss_halt,
  input logic cpu_clk_en,
  input logic cpu_clk_2x_en,
  input logic cpu_reset
);

  timeunit 1ns;
  timeprecision 100ps;

  // every 1x tick is also a 2x tick
  enable_pairing: assert property (@(posedge clk_sys_117_964)
    cpu_clk_en |-> cpu_clk_2x_en)
    else $error("cpu_clk_en high without cpu_clk_2x_en");

  // savestate halt freezes both enables
  halt_blocks_enables: assert property (@(posedge clk_sys_117_964)
    ss_halt |-> (!cpu_clk_en && !cpu_clk_2x_en))
    else $error("CPU enable high while ss_halt is high");

  // system reset always reaches the CPU
  reset_reaches_cpu: assert property (@(posedge clk_sys_117_964)
    reset_turbo_s |-> cpu_reset)
    else $error("cpu_reset low while reset_turbo_s is high");

endmodule

/* tb_tama_core.sv */
// testbench for the tama core
// directed tests over the bridge registers, divider, program ROM,
// reset sources, audio and savestate halt

`include "tama_settings.svh"

module tb_tama_core import tama_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  logic          clk_sys_117_964;
  logic          reset_turbo_s;
  bridge_addr_t  bridge_addr;
  logic          bridge_wr;
  logic          bridge_rd;
  bridge_data_t  bridge_wr_data;
  bridge_data_t  bridge_rd_data;
  rom_addr_t     rom_addr;
  rom_data_t     rom_data;
  logic          buzzer;
  logic          ss_halt;
  logic          ss_begin_reset;
  logic          cpu_clk_en;
  logic          cpu_clk_2x_en;
  logic          cpu_reset;
  audio_sample_t audio_sample;

  int seed;
  int error_count;
  int cycle_count = 0;

  // two 1x periods dominate, the rest is a few thousand cycles
  localparam int max_cycles = 30000;

  tama_core_top tama_core_top_inst (
    .clk_sys_117_964 (clk_sys_117_964),
    .reset_turbo_s   (reset_turbo_s),
    .bridge_addr     (bridge_addr),
    .bridge_wr       (bridge_wr),
    .bridge_rd       (bridge_rd),
    .bridge_wr_data  (bridge_wr_data),
    .bridge_rd_data  (bridge_rd_data),
    .rom_addr        (rom_addr),
    .rom_data        (rom_data),
    .buzzer          (buzzer),
    .ss_halt         (ss_halt),
    .ss_begin_reset  (ss_begin_reset),
    .cpu_clk_en      (cpu_clk_en),
    .cpu_clk_2x_en   (cpu_clk_2x_en),
    .cpu_reset       (cpu_reset),
    .audio_sample    (audio_sample)
  );

  bind tama_core_top tama_asserts tama_asserts_inst (
    .clk_sys_117_964 (clk_sys_117_964),
    .reset_turbo_s   (reset_turbo_s),
    .ss_halt         (ss_halt),
    .cpu_clk_en      (cpu_clk_en),
    .cpu_clk_2x_en   (cpu_clk_2x_en),
    .cpu_reset       (cpu_reset)
  );

  initial begin
    clk_sys_117_964 = 1'b0;
    forever #5 clk_sys_117_964 = ~clk_sys_117_964;
  end

  always @(posedge clk_sys_117_964) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout: the run did not finish within %0d clock cycles", max_cycles);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("FAILED %s: expected %0h, actual %0h", test_name, expected, actual);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////
  // bridge access, called on a falling edge

  task automatic write_bridge(input bridge_addr_t addr, input bridge_data_t data);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    @(negedge clk_sys_117_964);
    bridge_wr = 1'b0;
  endtask

  task automatic read_bridge(input bridge_addr_t addr, output bridge_data_t data);
    bridge_addr = addr;
    bridge_rd   = 1'b1;
    #1;
    data = bridge_rd_data;
    @(negedge clk_sys_117_964);
    bridge_rd = 1'b0;
  endtask

  // clk_en period in system clocks for a turbo code
  function automatic int expected_gap(input turbo_t code);
    case (turbo_e'(code))
      turbo_1x:  return `TAMA_DIV_1X + 1;
      turbo_4x:  return `TAMA_DIV_4X + 1;
      turbo_50x: return `TAMA_DIV_50X + 1;
      default:   return 2;
    endcase
  endfunction

  // chosen half of the bridge word, bytes swapped, low 12 bits
  function automatic rom_data_t expected_rom(input bridge_data_t word, input logic odd);
    logic [15:0] half;
    logic [15:0] swapped;
    half    = odd ? word[15:0] : word[31:16];
    swapped = {half[7:0], half[15:8]};
    return swapped[11:0];
  endfunction

  ////////////////////////////////////////
  // tests

  task automatic test_registers();
    bridge_data_t data;
    int           code;
    read_bridge(`TAMA_ADDR_TURBO, data);
    check_value("turbo after reset", 32'h0, data);
    check_value("cpu_reset after reset", 32'h0, 32'(cpu_reset));
    for (code = 0; code < 4; code++) begin
      write_bridge(`TAMA_ADDR_TURBO, bridge_data_t'(code));
      read_bridge(`TAMA_ADDR_TURBO, data);
      check_value("turbo readback", 32'(code), data);
    end
    // sound register is write only, even with mute set
    write_bridge(`TAMA_ADDR_SOUND, 32'h1);
    read_bridge(`TAMA_ADDR_SOUND, data);
    check_value("sound read", 32'h0, data);
    write_bridge(`TAMA_ADDR_SOUND, 32'h0);
    read_bridge(32'h0000_0200, data);
    check_value("unmapped read", 32'h0, data);
    // buzzer with the cancel flag drops turbo to 1x
    write_bridge(`TAMA_ADDR_CANCEL, 32'h1);
    buzzer = 1'b1;
    @(negedge clk_sys_117_964);
    buzzer = 1'b0;
    read_bridge(`TAMA_ADDR_TURBO, data);
    check_value("turbo cancel", 32'h0, data);
    write_bridge(`TAMA_ADDR_CANCEL, 32'h0);
  endtask

  task automatic check_divider(input turbo_t code);
    int gap;
    int pulses_2x;
    write_bridge(`TAMA_ADDR_TURBO, bridge_data_t'(code));
    // skip the enable set up under the old speed
    @(negedge clk_sys_117_964);
    while (!cpu_clk_en) begin
      @(negedge clk_sys_117_964);
    end
    gap       = 0;
    pulses_2x = 0;
    do begin
      @(negedge clk_sys_117_964);
      gap++;
      if (cpu_clk_2x_en) begin
        pulses_2x++;
      end
    end while (!cpu_clk_en);
    check_value("divider period", 32'(expected_gap(code)), 32'(gap));
    check_value("divider 2x pulses", 32'd2, 32'(pulses_2x));
  endtask

  task automatic test_rom();
    bridge_data_t words [16];
    logic [11:0]  rom_index [16];
    for (int i = 0; i < 16; i++) begin
      rom_index[i] = 12'(i * 193 + 5);
      words[i]     = $random(seed);
      write_bridge({`TAMA_ROM_WINDOW, 14'h0, rom_index[i], 2'b00}, words[i]);
    end
    for (int i = 0; i < 16; i++) begin
      for (int half = 0; half < 2; half++) begin
        rom_addr = {rom_index[i], half[0]};
        @(negedge clk_sys_117_964);
        check_value("rom read", 32'(expected_rom(words[i], half[0])), 32'(rom_data));
      end
    end
  endtask

  task automatic test_soft_reset();
    int high_cycles;
    check_value("reset idle", 32'h0, 32'(cpu_reset));
    write_bridge(`TAMA_ADDR_RESET, 32'h0);
    high_cycles = 0;
    while (cpu_reset) begin
      high_cycles++;
      @(negedge clk_sys_117_964);
    end
    check_value("soft reset hold", 32'(`TAMA_RESET_HOLD), 32'(high_cycles));
  endtask

  // 50x so the four 2x ticks are spread out
  task automatic test_ss_reset();
    int ticks;
    write_bridge(`TAMA_ADDR_TURBO, 32'h2);
    ss_begin_reset = 1'b1;
    @(negedge clk_sys_117_964);
    ss_begin_reset = 1'b0;
    check_value("ss reset start", 32'h1, 32'(cpu_reset));
    ticks = 0;
    while (cpu_reset) begin
      if (cpu_clk_2x_en) begin
        ticks++;
      end
      @(negedge clk_sys_117_964);
    end
    check_value("ss reset ticks", 32'(`TAMA_SS_RESET_TICKS), 32'(ticks));
  endtask

  task automatic test_audio_halt();
    buzzer = 1'b1;
    @(negedge clk_sys_117_964);
    check_value("audio buzzer", 32'h1fff, 32'(audio_sample));
    write_bridge(`TAMA_ADDR_SOUND, 32'h1);
    check_value("audio muted", 32'h0, 32'(audio_sample));
    write_bridge(`TAMA_ADDR_SOUND, 32'h0);
    buzzer = 1'b0;
    // still at 50x, hold over two full periods
    ss_halt = 1'b1;
    repeat (2 * (`TAMA_DIV_50X + 1)) begin
      @(negedge clk_sys_117_964);
      check_value("halt clk_en", 32'h0, 32'(cpu_clk_en));
      check_value("halt clk_2x_en", 32'h0, 32'(cpu_clk_2x_en));
    end
    ss_halt = 1'b0;
    while (!cpu_clk_en) begin
      @(negedge clk_sys_117_964);
    end
  endtask

  ////////////////////////////////////////
  // main sequence

  initial begin
    seed           = 32'h941a;
    error_count    = 0;
    reset_turbo_s  = 1'b1;
    bridge_addr    = '0;
    bridge_wr      = 1'b0;
    bridge_rd      = 1'b0;
    bridge_wr_data = '0;
    rom_addr       = '0;
    buzzer         = 1'b0;
    ss_halt        = 1'b0;
    ss_begin_reset = 1'b0;
    repeat (8) @(negedge clk_sys_117_964);
    check_value("reset cpu_reset", 32'h1, 32'(cpu_reset));
    check_value("reset clk_en", 32'h0, 32'(cpu_clk_en));
    check_value("reset clk_2x_en", 32'h0, 32'(cpu_clk_2x_en));
    reset_turbo_s = 1'b0;
    @(negedge clk_sys_117_964);

    test_registers();
    for (int code = 0; code < 4; code++) begin
      check_divider(turbo_t'(code));
    end
    test_rom();
    test_soft_reset();
    test_ss_reset();
    test_audio_halt();

    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+.
tama_pkg.sv
bridge_if.sv
bridge_regs.sv
clock_enable_gen.sv
program_rom.sv
cpu_control.sv
tama_core_top.sv
tama_asserts.sv
tb_tama_core.sv

/* Makefile */
# Verilator build for the tama core testbench

TOP = tb_tama_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o sim_tama
	./obj_dir/sim_tama | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
